// ==== verilog/mem_pkg.sv ====
// RAM geometry constants and the address and word types
// Shared by the RAM, the APB port, the top level and the reference model

package mem_pkg;

  // Word count and address width
  localparam int MEM_DEPTH = 1024;
  localparam int MEM_AW    = 10;

  // Full word width, split into the APB-visible low part and the upper bits
  localparam int MEM_DW    = 36;
  localparam int MEM_LO_W  = 32;
  localparam int MEM_HI_W  = MEM_DW - MEM_LO_W;

  // Every word holds this after init
  localparam logic [MEM_DW-1:0] MEM_INIT_WORD = 36'h0A5A5A5A5;

  // RAM word address
  typedef logic [MEM_AW-1:0] mem_addr_t;

  // Full RAM word
  typedef logic [MEM_DW-1:0] mem_word_t;

  // Upper bits of a word, bits 35 to 32
  typedef logic [MEM_HI_W-1:0] mem_hi_t;

endpackage

// ==== verilog/apb_pkg.sv ====
// APB bus widths, register map offsets and window bounds
// Packed request and response structs for the slave port

package apb_pkg;

  // Bus widths
  localparam int APB_AW = 16;
  localparam int APB_DW = 32;

  typedef logic [APB_AW-1:0] apb_addr_t;
  typedef logic [APB_DW-1:0] apb_data_t;

  // Register map
  localparam apb_addr_t REG_HI_STAGE   = 16'h0000;  // RW, upper bits for next window write
  localparam apb_addr_t REG_HI_CAPTURE = 16'h0004;  // RO, upper bits of last window read
  localparam apb_addr_t REG_PREV_LO    = 16'h0008;  // RO, low bits of replaced word
  localparam apb_addr_t REG_PREV_HI    = 16'h000C;  // RO, upper bits of replaced word

  // Memory window, word n at WIN_BASE + 4*n
  localparam apb_addr_t WIN_BASE = 16'h1000;
  localparam apb_addr_t WIN_LAST = 16'h1FFC;

  // Request from the master, held stable through the access cycle
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Response from the slave
  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

endpackage

// ==== verilog/memory_generator.sv ====
// Read-first single-port synchronous RAM, 1024 x 36
// All words start at the package init value
`timescale 1ns/1ps

module memory_generator (
  input  logic               clka,
  input  mem_pkg::mem_addr_t addra,
  input  logic               en,
  input  mem_pkg::mem_word_t data_in,
  output mem_pkg::mem_word_t douta
);
  import mem_pkg::*;

  // Storage array, maps onto a block RAM
  mem_word_t mem [MEM_DEPTH];

  // Uniform init value for every word
  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = MEM_INIT_WORD;
    end
  end

  // Read port
  // Old contents at addra appear on douta one cycle later
  always_ff @(posedge clka) begin
    douta <= mem[addra];
  end

  // Write port
  // Same edge as the read, the read above still sees the old word
  always_ff @(posedge clka) begin
    if (en) begin
      mem[addra] <= data_in;
    end
  end

  // No reset here
  // Contents survive a system reset

endmodule

// ==== verilog/apb_mem_port.sv ====
// APB slave for the 36-bit RAM: address decode, window access, read mux
// Staging, capture and previous-word registers
`timescale 1ns/1ps

module apb_mem_port (
  input  logic               clka,
  input  logic               rst_n,
  input  apb_pkg::apb_req_t  apb_req,
  output apb_pkg::apb_rsp_t  apb_rsp,
  output mem_pkg::mem_addr_t addra,
  output logic               en,
  output mem_pkg::mem_word_t data_in,
  input  mem_pkg::mem_word_t douta
);
  import mem_pkg::*;
  import apb_pkg::*;

  // Transfer phase
  logic      access;

  // Address decode
  logic      win_hit;
  logic      hit_stage;
  logic      hit_capture;
  logic      hit_prev_lo;
  logic      hit_prev_hi;
  logic      reg_hit;
  logic      ro_write;
  logic      slverr;

  // Qualified actions, only in an error-free access cycle
  logic      win_wr;
  logic      win_rd;
  logic      stage_wr;

  // Side registers around the RAM
  mem_hi_t   hi_stage;
  mem_hi_t   hi_capture;
  apb_data_t prev_lo;
  mem_hi_t   prev_hi;

  // Read mux result
  apb_data_t rd_data;

  // Access cycle, pready is always high here
  assign access = apb_req.psel & apb_req.penable;

  // Window covers 0x1000..0x1FFC, word aligned only
  assign win_hit = (apb_req.paddr >= WIN_BASE) &&
                   (apb_req.paddr <= WIN_LAST) &&
                   (apb_req.paddr[1:0] == 2'b00);

  // Exact match on register offsets
  assign hit_stage   = (apb_req.paddr == REG_HI_STAGE);
  assign hit_capture = (apb_req.paddr == REG_HI_CAPTURE);
  assign hit_prev_lo = (apb_req.paddr == REG_PREV_LO);
  assign hit_prev_hi = (apb_req.paddr == REG_PREV_HI);
  assign reg_hit     = hit_stage | hit_capture | hit_prev_lo | hit_prev_hi;

  // Only the staging register accepts writes
  assign ro_write = apb_req.pwrite & (hit_capture | hit_prev_lo | hit_prev_hi);

  // Unmapped address or write to a read-only register
  assign slverr = (!win_hit && !reg_hit) || ro_write;

  assign win_wr   = access &  apb_req.pwrite & win_hit;
  assign win_rd   = access & !apb_req.pwrite & win_hit;
  assign stage_wr = access &  apb_req.pwrite & hit_stage;

  // Word address from the window offset
  // Driven in setup already so the RAM reads at the end of setup
  assign addra = apb_req.paddr[MEM_AW+1:2];

  // RAM write in the access cycle, upper bits from staging
  assign en      = win_wr;
  assign data_in = {hi_stage, apb_req.pwdata};

  // Read data
  // Window reads take douta, which holds the word read at end of setup
  always_comb begin
    rd_data = '0;
    if (win_hit) begin
      rd_data = douta[MEM_LO_W-1:0];
    end else if (hit_stage) begin
      rd_data = {{(APB_DW-MEM_HI_W){1'b0}}, hi_stage};
    end else if (hit_capture) begin
      rd_data = {{(APB_DW-MEM_HI_W){1'b0}}, hi_capture};
    end else if (hit_prev_lo) begin
      rd_data = prev_lo;
    end else if (hit_prev_hi) begin
      rd_data = {{(APB_DW-MEM_HI_W){1'b0}}, prev_hi};
    end
  end

  // Response, valid only with pready
  assign apb_rsp.pready  = access;
  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pslverr = access & slverr;

  // Staging register, low bits of pwdata
  always_ff @(posedge clka) begin
    if (!rst_n) begin
      hi_stage <= '0;
    end else if (stage_wr) begin
      hi_stage <= apb_req.pwdata[MEM_HI_W-1:0];
    end
  end

  // Capture of the upper bits at the end of a window read
  always_ff @(posedge clka) begin
    if (!rst_n) begin
      hi_capture <= '0;
    end else if (win_rd) begin
      hi_capture <= douta[MEM_DW-1:MEM_LO_W];
    end
  end

  // Previous word, latched on the same edge that writes the RAM
  // douta still holds the old contents at that point
  always_ff @(posedge clka) begin
    if (!rst_n) begin
      prev_lo <= '0;
      prev_hi <= '0;
    end else if (win_wr) begin
      prev_lo <= douta[MEM_LO_W-1:0];
      prev_hi <= douta[MEM_DW-1:MEM_LO_W];
    end
  end

  // Error cases never reach win_wr, win_rd or stage_wr
  // so a failed access leaves all state as it was

endmodule

// ==== verilog/mem_subsys_top.sv ====
// Memory subsystem top: APB slave port in front of the 36-bit RAM
// Single APB request and response struct at the boundary
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic              clka,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp
);
  import mem_pkg::*;

  // RAM side of the port
  mem_addr_t addra;
  logic      en;
  mem_word_t data_in;
  mem_word_t douta;

  // APB decode and side registers
  apb_mem_port u_port (
    .clka    (clka),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .addra   (addra),
    .en      (en),
    .data_in (data_in),
    .douta   (douta)
  );

  // Storage
  // Has no reset input, contents persist across rst_n
  memory_generator u_ram (
    .clka    (clka),
    .addra   (addra),
    .en      (en),
    .data_in (data_in),
    .douta   (douta)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset, 100 ns period
// Power-on reset for 3 cycles, later resets on request
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic reset_req,
  output logic clka,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;
  localparam int POR_CYCLES  = 3;

  // Free-running clock
  initial begin
    clka = 1'b0;
    forever #HALF_PERIOD clka = ~clka;
  end

  // Low for the power-on cycles, then follows reset_req one edge late
  initial begin
    rst_n = 1'b0;
    repeat (POR_CYCLES) @(posedge clka);
    rst_n <= 1'b1;
    forever begin
      @(posedge clka);
      rst_n <= !reset_req;
    end
  end

endmodule

// ==== verif/mem_ref_model.sv ====
// Reference model of the 36-bit RAM and the APB register map
// Predicts prdata and pslverr of every access cycle
`timescale 1ns/1ps

module mem_ref_model (
  input  logic              clka,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t exp_rsp
);
  import mem_pkg::*;
  import apb_pkg::*;

  // Model state, whole words kept as written
  mem_word_t model_mem [MEM_DEPTH];
  mem_hi_t   stage_q;
  mem_hi_t   capture_q;
  mem_word_t prev_q;

  logic      xfer;
  logic      in_window;
  logic      is_reg;
  logic      bad;
  apb_addr_t offs;
  mem_addr_t word_idx;

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      model_mem[i] = MEM_INIT_WORD;
    end
  end

  // Decode and expected response
  always_comb begin
    xfer      = apb_req.psel && apb_req.penable;
    in_window = (apb_req.paddr >= WIN_BASE) && (apb_req.paddr <= WIN_LAST) &&
                (apb_req.paddr[1:0] == 2'b00);
    offs      = apb_req.paddr - WIN_BASE;
    word_idx  = offs[MEM_AW+1:2];
    is_reg    = (apb_req.paddr == REG_HI_STAGE) || (apb_req.paddr == REG_HI_CAPTURE) ||
                (apb_req.paddr == REG_PREV_LO) || (apb_req.paddr == REG_PREV_HI);
    // Unmapped, or a write anywhere in the map but the staging register
    bad = !(in_window || is_reg) ||
          (apb_req.pwrite && is_reg && (apb_req.paddr != REG_HI_STAGE));
    exp_rsp.pready  = xfer;
    exp_rsp.pslverr = xfer && bad;
    exp_rsp.prdata  = '0;
    if (in_window) begin
      exp_rsp.prdata = model_mem[word_idx][APB_DW-1:0];
    end else if (apb_req.paddr == REG_HI_STAGE) begin
      exp_rsp.prdata = {{(APB_DW-MEM_HI_W){1'b0}}, stage_q};
    end else if (apb_req.paddr == REG_HI_CAPTURE) begin
      exp_rsp.prdata = {{(APB_DW-MEM_HI_W){1'b0}}, capture_q};
    end else if (apb_req.paddr == REG_PREV_LO) begin
      exp_rsp.prdata = prev_q[APB_DW-1:0];
    end else if (apb_req.paddr == REG_PREV_HI) begin
      exp_rsp.prdata = {{(APB_DW-MEM_HI_W){1'b0}}, prev_q[MEM_DW-1:APB_DW]};
    end
  end

  // State updates at the end of a good access cycle, memory kept over reset
  always @(posedge clka) begin
    if (!rst_n) begin
      stage_q   <= '0;
      capture_q <= '0;
      prev_q    <= '0;
    end else if (xfer && !bad) begin
      if (in_window && apb_req.pwrite) begin
        prev_q              <= model_mem[word_idx];
        model_mem[word_idx] <= {stage_q, apb_req.pwdata};
      end else if (in_window) begin
        capture_q <= model_mem[word_idx][MEM_DW-1:APB_DW];
      end else if (apb_req.pwrite) begin
        stage_q <= apb_req.pwdata[MEM_HI_W-1:0];
      end
    end
  end

endmodule

// ==== verif/tb_mem_subsys.sv ====
// Testbench top for the APB memory subsystem
// APB driver tasks, directed tests, watchdog and summary
`timescale 1ns/1ps

module tb_mem_subsys;
  import mem_pkg::*;
  import apb_pkg::*;

  localparam int N_RAND          = 16;
  localparam int CLK_PERIOD_NS   = 100;
  // Two cycles per transfer plus reset and idle slack
  localparam int TEST_XFERS      = 9 * N_RAND + 40;
  localparam int WATCHDOG_CYCLES = 2 * TEST_XFERS + 200;

  logic     clka;
  logic     rst_n;
  logic     reset_req;
  logic     last_err;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  apb_rsp_t exp_rsp;
  int       errors;
  int       seed;
  string    test_name;

  tb_clock_gen clk_gen (.reset_req(reset_req), .clka(clka), .rst_n(rst_n));

  mem_subsys_top UUT (.clka(clka), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp));

  mem_ref_model ref_model (.clka(clka), .rst_n(rst_n), .apb_req(apb_req), .exp_rsp(exp_rsp));

  task automatic check_value(input string what, input apb_data_t expected,
                             input apb_data_t actual);
    assert (expected == actual) else begin
      errors++;
      $display("Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // Lower half only, upper half kept unwritten for the read-first test
  function automatic mem_addr_t rand_addr();
    apb_data_t rnd;
    rnd = $random(seed);
    return {1'b0, rnd[8:0]};
  endfunction

  function automatic apb_data_t rand_data();
    return $random(seed);
  endfunction

  function automatic apb_addr_t win_addr(input mem_addr_t a);
    return WIN_BASE + {4'h0, a, 2'b00};
  endfunction

  function automatic apb_data_t hi_ext(input mem_hi_t h);
    return {{(APB_DW-MEM_HI_W){1'b0}}, h};
  endfunction

  // Setup then access cycle, each sampled mid-cycle
  // pready low in setup and high in access, no wait states
  task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge clka);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(negedge clka);
    check_value("pready setup", 32'(exp_rsp.pready), 32'(apb_rsp.pready));
    @(posedge clka);
    apb_req.penable <= 1'b1;
    @(negedge clka);
    check_value("pready access", 32'(exp_rsp.pready), 32'(apb_rsp.pready));
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value("pslverr", 32'(exp_rsp.pslverr), 32'(err));
    if (!write && !exp_rsp.pslverr) begin
      check_value("prdata", exp_rsp.prdata, rdata);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rd_dummy;
    apb_xfer(1'b1, addr, data, rd_dummy, last_err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    apb_xfer(1'b0, addr, '0, data, last_err);
  endtask

  task automatic bus_idle();
    @(posedge clka);
    apb_req <= '0;
  endtask

  task automatic expect_error(input logic write, input apb_addr_t addr);
    apb_data_t rd;
    apb_xfer(write, addr, 32'hFFFF_FFFF, rd, last_err);
    check_value("pslverr set", 32'd1, 32'(last_err));
  endtask

  task automatic test_init();
    apb_data_t rd;
    test_name = "init";
    for (int i = 0; i < N_RAND; i++) begin
      apb_read(win_addr(rand_addr()), rd);
      check_value("word", MEM_INIT_WORD[APB_DW-1:0], rd);
      apb_read(REG_HI_CAPTURE, rd);
      check_value("capture", hi_ext(MEM_INIT_WORD[MEM_DW-1:APB_DW]), rd);
    end
  endtask

  // Staging register takes the low 4 bits of pwdata
  task automatic test_full_word();
    mem_addr_t a;
    apb_data_t wd;
    apb_data_t hi;
    apb_data_t rd;
    test_name = "full_word";
    for (int i = 0; i < N_RAND; i++) begin
      a  = (i == 0) ? 10'd0 : (i == 1) ? 10'd1023 : rand_addr();
      wd = rand_data();
      hi = rand_data();
      apb_write(REG_HI_STAGE, hi);
      apb_write(win_addr(a), wd);
      apb_read(win_addr(a), rd);
      check_value("low bits", wd, rd);
      apb_read(REG_HI_CAPTURE, rd);
      check_value("high bits", hi & 32'hF, rd);
    end
  endtask

  task automatic test_read_first();
    apb_data_t rd;
    test_name = "read_first";
    apb_write(REG_HI_STAGE, 32'h3);
    apb_write(win_addr(10'd777), 32'h1234_5678);
    apb_read(REG_PREV_LO, rd);
    check_value("prev_lo init", MEM_INIT_WORD[APB_DW-1:0], rd);
    apb_read(REG_PREV_HI, rd);
    check_value("prev_hi init", hi_ext(MEM_INIT_WORD[MEM_DW-1:APB_DW]), rd);
    apb_write(REG_HI_STAGE, 32'hC);
    apb_write(win_addr(10'd777), 32'h9ABC_DEF0);
    apb_read(REG_PREV_LO, rd);
    check_value("prev_lo first", 32'h1234_5678, rd);
    apb_read(REG_PREV_HI, rd);
    check_value("prev_hi first", 32'h3, rd);
  endtask

  // No idle cycles between transfers
  task automatic test_back_to_back();
    mem_addr_t a;
    apb_data_t wd;
    apb_data_t rd;
    test_name = "back_to_back";
    for (int i = 0; i < N_RAND; i++) begin
      a  = rand_addr();
      wd = rand_data();
      apb_write(win_addr(a), wd);
      apb_read(win_addr(a), rd);
      check_value("readback", wd, rd);
      apb_read(win_addr(rand_addr()), rd);
    end
  endtask

  task automatic test_errors();
    apb_data_t word0;
    apb_data_t cap;
    apb_data_t plo;
    apb_data_t rd;
    test_name = "errors";
    apb_read(win_addr(10'd0), word0);
    apb_read(REG_HI_CAPTURE, cap);
    apb_read(REG_PREV_LO, plo);
    expect_error(1'b1, REG_HI_CAPTURE);
    expect_error(1'b1, REG_PREV_LO);
    expect_error(1'b1, REG_PREV_HI);
    expect_error(1'b1, 16'h0800);
    expect_error(1'b0, 16'h0800);
    // 0x2000 would alias word 0 if decoded wrongly
    expect_error(1'b1, 16'h2000);
    expect_error(1'b0, 16'h2000);
    expect_error(1'b1, 16'h1002);
    apb_read(REG_HI_CAPTURE, rd);
    check_value("capture kept", cap, rd);
    apb_read(REG_PREV_LO, rd);
    check_value("prev_lo kept", plo, rd);
    apb_read(win_addr(10'd0), rd);
    check_value("word 0 kept", word0, rd);
    // Remaining state against the model, 0x0800 would alias word 512
    apb_read(REG_HI_STAGE, rd);
    apb_read(REG_PREV_HI, rd);
    apb_read(win_addr(10'd512), rd);
  endtask

  task automatic test_reset();
    apb_addr_t regs [4] = '{REG_HI_STAGE, REG_HI_CAPTURE, REG_PREV_LO, REG_PREV_HI};
    apb_data_t rd;
    test_name = "reset";
    // Every register nonzero before the reset
    apb_write(REG_HI_STAGE, 32'h5);
    apb_write(win_addr(10'd900), 32'hCAFE_F00D);
    apb_write(win_addr(10'd900), 32'hCAFE_F00D);
    apb_read(win_addr(10'd900), rd);
    bus_idle();
    reset_req <= 1'b1;
    repeat (3) @(posedge clka);
    reset_req <= 1'b0;
    do @(negedge clka); while (!rst_n);
    for (int i = 0; i < 4; i++) begin
      apb_read(regs[i], rd);
      check_value("register cleared", 32'h0, rd);
    end
    apb_read(win_addr(10'd900), rd);
    check_value("word kept", 32'hCAFE_F00D, rd);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    errors    = 0;
    seed      = 77045;
    reset_req = 1'b0;
    last_err  = 1'b0;
    apb_req   = '0;
    test_name = "none";
    do @(negedge clka); while (!rst_n);
    test_init();
    test_full_word();
    test_read_first();
    test_back_to_back();
    test_errors();
    test_reset();
    bus_idle();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/mem_pkg.sv
verilog/apb_pkg.sv
verilog/memory_generator.sv
verilog/apb_mem_port.sv
verilog/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/mem_ref_model.sv
verif/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the APB memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation ended without a result"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
